//--- source/dcache_geom_pkg.sv
package dcache_geom_pkg;

  // stored tag width and associativity
  localparam int tag_bits = 20;
  localparam int num_ways = 4;

  typedef logic [1:0] way_idx_t;

  // one stored entry, parity makes the xor of all 23 bits zero
  typedef struct packed {
    logic [tag_bits-1:0] tag;
    logic                valid;
    logic                excl;
    logic                parity;
  } tag_entry_t;

  // per-way result of a read, taken from the RAM output
  typedef struct packed {
    logic                hit;
    logic                valid;
    logic                excl;
    logic                err;
    logic [tag_bits-1:0] tag;
  } way_status_t;

endpackage

//--- source/dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

  // request opcodes seen on the request port
  typedef enum logic [1:0] {
    op_lookup = 2'd0,
    op_fill   = 2'd1,
    op_inval  = 2'd2
  } tag_op_t;

  // controller states
  typedef enum logic [1:0] {
    st_sweep  = 2'd0,
    st_idle   = 2'd1,
    st_update = 2'd2
  } ctrl_state_t;

endpackage

//--- source/dcache_tag_if.sv
`timescale 1ns/100ps

interface dcache_tag_if #(
  parameter int SET_BITS = 6
);
  import dcache_geom_pkg::*;

  // read side, address is registered inside each RAM
  logic                rd_en;
  logic [SET_BITS-1:0] rd_set;
  // request tag, lines up with the RAM output
  logic [tag_bits-1:0] cmp_tag;

  // write side, one enable bit per way
  logic [SET_BITS-1:0] wr_set;
  tag_entry_t          wr_entry;
  logic [num_ways-1:0] wr_way;

  modport ctrl (
    output rd_en, rd_set, cmp_tag, wr_set, wr_entry, wr_way
  );

  modport way (
    input rd_en, rd_set, cmp_tag, wr_set, wr_entry, wr_way
  );

endinterface

//--- source/dcache_tag_ram.sv
`timescale 1ns/100ps

module dcache_tag_ram #(
  parameter int SET_BITS = 6
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        rd_en,
  input  logic [SET_BITS-1:0]         rd_set,
  output dcache_geom_pkg::tag_entry_t rd_entry,
  input  logic                        wr_en,
  input  logic [SET_BITS-1:0]         wr_set,
  input  dcache_geom_pkg::tag_entry_t wr_entry
);
  import dcache_geom_pkg::*;

  tag_entry_t          mem [2**SET_BITS];
  logic [SET_BITS-1:0] rd_addr;

  // data follows the held address, so a write shows up on the next cycle
  assign rd_entry = mem[rd_addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr <= '0;
    end else if (rd_en) begin
      rd_addr <= rd_set;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_set] <= wr_entry;
    end
  end

endmodule

//--- source/dcache_tag_way.sv
`timescale 1ns/100ps

module dcache_tag_way #(
  parameter int SET_BITS = 6,
  parameter int WAY      = 0
) (
  input  logic                         clk,
  input  logic                         rst,
  dcache_tag_if.way                    tag_bus,
  output dcache_geom_pkg::way_status_t status
);
  import dcache_geom_pkg::*;

  tag_entry_t rd_entry;
  logic       wr_en;
  logic       par_err;
  logic       tag_match;

  // only this way's bit of the mask writes here
  assign wr_en = tag_bus.wr_way[WAY];

  dcache_tag_ram #(
    .SET_BITS(SET_BITS)
  ) u_ram (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (tag_bus.rd_en),
    .rd_set  (tag_bus.rd_set),
    .rd_entry(rd_entry),
    .wr_en   (wr_en),
    .wr_set  (tag_bus.wr_set),
    .wr_entry(tag_bus.wr_entry)
  );

  // even parity over the whole entry
  assign par_err   = ^rd_entry;
  assign tag_match = (rd_entry.tag == tag_bus.cmp_tag);

  // a corrupted entry never counts as a hit
  assign status.hit   = tag_match & rd_entry.valid & ~par_err;
  assign status.valid = rd_entry.valid;
  assign status.excl  = rd_entry.excl;
  assign status.err   = par_err;
  assign status.tag   = rd_entry.tag;

endmodule

//--- source/dcache_sweep_counter.sv
`timescale 1ns/100ps

module dcache_sweep_counter #(
  parameter int SET_BITS = 6
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                sweep_en,
  output logic [SET_BITS-1:0] count,
  output logic                last
);

  // steps through the sets while the sweep runs
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (sweep_en) begin
      count <= count + 1'b1;
    end
  end

  // top set reached
  assign last = &count;

endmodule

//--- source/dcache_way_select.sv
`timescale 1ns/100ps

module dcache_way_select (
  input  logic                                       clk,
  input  logic                                       rst,
  input  dcache_geom_pkg::way_status_t               status0,
  input  dcache_geom_pkg::way_status_t               status1,
  input  dcache_geom_pkg::way_status_t               status2,
  input  dcache_geom_pkg::way_status_t               status3,
  input  logic                                       fill_commit,
  output logic                                       hit,
  output dcache_geom_pkg::way_idx_t                  hit_way,
  output dcache_geom_pkg::way_idx_t                  victim_way,
  output logic                                       victim_valid,
  output logic                                       resp_excl,
  output logic                                       resp_err,
  output logic [dcache_geom_pkg::tag_bits-1:0]       evict_tag
);
  import dcache_geom_pkg::*;

  way_status_t st [num_ways];
  way_idx_t    repl_ptr;
  way_idx_t    free_way;
  logic        any_free;

  assign st[0] = status0;
  assign st[1] = status1;
  assign st[2] = status2;
  assign st[3] = status3;

  // scan downwards so the lowest matching way wins
  always_comb begin
    hit      = 1'b0;
    hit_way  = '0;
    any_free = 1'b0;
    free_way = '0;
    resp_err = 1'b0;
    for (int i = num_ways - 1; i >= 0; i--) begin
      if (st[i].hit) begin
        hit     = 1'b1;
        hit_way = way_idx_t'(i);
      end
      if (!st[i].valid) begin
        any_free = 1'b1;
        free_way = way_idx_t'(i);
      end
      resp_err = resp_err | st[i].err;
    end
  end

  // fill target: reuse on hit, then a free way, then the pointer
  assign victim_way   = hit ? hit_way : (any_free ? free_way : repl_ptr);
  assign victim_valid = st[victim_way].valid;
  assign evict_tag    = st[victim_way].tag;
  assign resp_excl    = hit & st[hit_way].excl;

  // pointer moves only when a valid line is pushed out
  always_ff @(posedge clk) begin
    if (rst) begin
      repl_ptr <= '0;
    end else if (fill_commit && !hit && victim_valid) begin
      repl_ptr <= repl_ptr + 2'd1;
    end
  end

endmodule

//--- source/dcache_tag_ctrl.sv
`timescale 1ns/100ps

module dcache_tag_ctrl #(
  parameter int SET_BITS = 6
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 req_valid,
  input  dcache_ctrl_pkg::tag_op_t             req_op,
  input  logic [SET_BITS-1:0]                  req_set,
  input  logic [dcache_geom_pkg::tag_bits-1:0] req_tag,
  input  logic                                 req_excl,
  output logic                                 ready,
  output logic                                 resp_valid,
  output logic                                 evict_valid,
  output logic                                 sweep_en,
  input  logic [SET_BITS-1:0]                  sweep_count,
  input  logic                                 sweep_last,
  input  logic                                 hit,
  input  dcache_geom_pkg::way_idx_t            hit_way,
  input  dcache_geom_pkg::way_idx_t            victim_way,
  input  logic                                 victim_valid,
  output logic                                 fill_commit,
  dcache_tag_if.ctrl                           tag_bus
);
  import dcache_geom_pkg::*;
  import dcache_ctrl_pkg::*;

  ctrl_state_t         state;
  tag_op_t             op_q;
  logic [SET_BITS-1:0] set_q;
  logic [tag_bits-1:0] tag_q;
  logic                excl_q;
  logic                accept;
  tag_entry_t          entry;

  assign ready    = (state == st_idle);
  assign accept   = req_valid & ready;
  assign sweep_en = (state == st_sweep);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_sweep;
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= accept;
      case (state)
        st_sweep:  if (sweep_last) state <= st_idle;
        st_idle:   if (accept && req_op != op_lookup) state <= st_update;
        default:   state <= st_idle;
      endcase
    end
  end

  // request payload held for the compare and the write
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q   <= req_op;
      set_q  <= req_set;
      tag_q  <= req_tag;
      excl_q <= req_excl;
    end
  end

  assign tag_bus.rd_en   = accept;
  assign tag_bus.rd_set  = req_set;
  assign tag_bus.cmp_tag = tag_q;

  assign fill_commit = (state == st_update) && (op_q == op_fill);
  assign evict_valid = fill_commit & ~hit & victim_valid;

  // sweep clears all ways, update writes one way or none
  always_comb begin
    entry          = '0;
    tag_bus.wr_set = set_q;
    tag_bus.wr_way = '0;
    if (state == st_sweep) begin
      tag_bus.wr_set = sweep_count;
      tag_bus.wr_way = '1;
    end else if (fill_commit) begin
      entry.tag   = tag_q;
      entry.valid = 1'b1;
      entry.excl  = excl_q;
      tag_bus.wr_way[victim_way] = 1'b1;
    end else if (state == st_update && op_q == op_inval && hit) begin
      // snoop drops the line, tag kept for debug
      entry.tag = tag_q;
      tag_bus.wr_way[hit_way] = 1'b1;
    end
    entry.parity     = ^{entry.tag, entry.valid, entry.excl};
    tag_bus.wr_entry = entry;
  end

endmodule

//--- source/dcache_tag_top.sv
`timescale 1ns/100ps

module dcache_tag_top #(
  parameter int SET_BITS = 6
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 req_valid,
  input  dcache_ctrl_pkg::tag_op_t             req_op,
  input  logic [SET_BITS-1:0]                  req_set,
  input  logic [dcache_geom_pkg::tag_bits-1:0] req_tag,
  input  logic                                 req_excl,
  output logic                                 ready,
  output logic                                 resp_valid,
  output logic                                 resp_hit,
  output dcache_geom_pkg::way_idx_t            resp_way,
  output logic                                 resp_excl,
  output logic                                 resp_err,
  output logic                                 evict_valid,
  output logic [dcache_geom_pkg::tag_bits-1:0] evict_tag
);
  import dcache_geom_pkg::*;

  way_status_t         way_status [num_ways];
  way_idx_t            victim_way;
  logic                victim_valid;
  logic                fill_commit;
  logic                sweep_en;
  logic                sweep_last;
  logic [SET_BITS-1:0] sweep_count;

  dcache_tag_if #(
    .SET_BITS(SET_BITS)
  ) tag_bus ();

  dcache_tag_ctrl #(
    .SET_BITS(SET_BITS)
  ) u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .req_valid   (req_valid),
    .req_op      (req_op),
    .req_set     (req_set),
    .req_tag     (req_tag),
    .req_excl    (req_excl),
    .ready       (ready),
    .resp_valid  (resp_valid),
    .evict_valid (evict_valid),
    .sweep_en    (sweep_en),
    .sweep_count (sweep_count),
    .sweep_last  (sweep_last),
    .hit         (resp_hit),
    .hit_way     (resp_way),
    .victim_way  (victim_way),
    .victim_valid(victim_valid),
    .fill_commit (fill_commit),
    .tag_bus     (tag_bus.ctrl)
  );

  dcache_sweep_counter #(
    .SET_BITS(SET_BITS)
  ) u_sweep (
    .clk     (clk),
    .rst     (rst),
    .sweep_en(sweep_en),
    .count   (sweep_count),
    .last    (sweep_last)
  );

  // four identical ways, each picks its own bit of the write mask
  for (genvar w = 0; w < num_ways; w++) begin : g_way
    dcache_tag_way #(
      .SET_BITS(SET_BITS),
      .WAY     (w)
    ) u_way (
      .clk    (clk),
      .rst    (rst),
      .tag_bus(tag_bus.way),
      .status (way_status[w])
    );
  end

  dcache_way_select u_select (
    .clk         (clk),
    .rst         (rst),
    .status0     (way_status[0]),
    .status1     (way_status[1]),
    .status2     (way_status[2]),
    .status3     (way_status[3]),
    .fill_commit (fill_commit),
    .hit         (resp_hit),
    .hit_way     (resp_way),
    .victim_way  (victim_way),
    .victim_valid(victim_valid),
    .resp_excl   (resp_excl),
    .resp_err    (resp_err),
    .evict_tag   (evict_tag)
  );

endmodule

//--- tests/tb_dcache_tag.sv
`timescale 1ns/100ps

module tb_dcache_tag;
  import dcache_geom_pkg::*;
  import dcache_ctrl_pkg::*;

  localparam int SET_BITS = 6;
  localparam int num_sets = 2**SET_BITS;

  // request counts per test size the watchdog
  localparam int n_miss  = 8;
  localparam int n_basic = 4;
  localparam int n_evict = 16;
  localparam int n_inval = 13;
  localparam int n_rand  = 300;
  localparam int n_req   = n_miss + n_basic + n_evict + n_inval + n_rand;
  localparam int watchdog_cycles = 4 + num_sets + 20 * n_req;

  typedef struct packed {
    logic                update;
    logic                hit;
    way_idx_t            way;
    logic                excl;
    logic                evict;
    logic [tag_bits-1:0] evict_tag;
  } expect_t;

  logic                clk;
  logic                rst;
  logic                req_valid;
  tag_op_t             req_op;
  logic [SET_BITS-1:0] req_set;
  logic [tag_bits-1:0] req_tag;
  logic                req_excl;
  logic                ready;
  logic                resp_valid;
  logic                resp_hit;
  way_idx_t            resp_way;
  logic                resp_excl;
  logic                resp_err;
  logic                evict_valid;
  logic [tag_bits-1:0] evict_tag;

  // expected contents of the tag array and the replacement pointer
  logic [tag_bits-1:0] ref_tag   [num_sets][num_ways];
  logic                ref_valid [num_sets][num_ways];
  logic                ref_excl  [num_sets][num_ways];
  way_idx_t            ref_ptr;

  expect_t exp_q [$];
  int      n_sent;
  int      n_resp;
  integer  seed;

  dcache_tag_top #(
    .SET_BITS(SET_BITS)
  ) u_dcache_tag_top (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_op     (req_op),
    .req_set    (req_set),
    .req_tag    (req_tag),
    .req_excl   (req_excl),
    .ready      (ready),
    .resp_valid (resp_valid),
    .resp_hit   (resp_hit),
    .resp_way   (resp_way),
    .resp_excl  (resp_excl),
    .resp_err   (resp_err),
    .evict_valid(evict_valid),
    .evict_tag  (evict_tag)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // predicts the response of one request and updates the expected array
  function automatic expect_t model_access(input tag_op_t op,
                                           input logic [SET_BITS-1:0] set_idx,
                                           input logic [tag_bits-1:0] tag,
                                           input logic excl);
    expect_t e;
    int      hw;
    int      tgt;
    e  = '0;
    hw = -1;
    for (int w = num_ways - 1; w >= 0; w--) begin
      if (ref_valid[set_idx][w] && ref_tag[set_idx][w] == tag) begin
        hw = w;
      end
    end
    e.update = (op != op_lookup);
    e.hit    = (hw >= 0);
    if (e.hit) begin
      e.way  = way_idx_t'(hw);
      e.excl = ref_excl[set_idx][hw];
    end
    if (op == op_fill) begin
      tgt = hw;
      // lowest invalid way comes before the pointer
      if (tgt < 0) begin
        for (int w = num_ways - 1; w >= 0; w--) begin
          if (!ref_valid[set_idx][w]) begin
            tgt = w;
          end
        end
      end
      if (tgt < 0) begin
        tgt         = int'(ref_ptr);
        e.evict     = 1'b1;
        e.evict_tag = ref_tag[set_idx][tgt];
        ref_ptr     = ref_ptr + 2'd1;
      end
      ref_tag[set_idx][tgt]   = tag;
      ref_valid[set_idx][tgt] = 1'b1;
      ref_excl[set_idx][tgt]  = excl;
    end else if (op == op_inval && e.hit) begin
      ref_valid[set_idx][hw] = 1'b0;
      ref_excl[set_idx][hw]  = 1'b0;
    end
    return e;
  endfunction

  // called on a falling edge and returns one falling edge after acceptance
  task automatic send(input tag_op_t op, input logic [SET_BITS-1:0] set_idx,
                      input logic [tag_bits-1:0] tag, input logic excl);
    req_valid = 1'b1;
    req_op    = op;
    req_set   = set_idx;
    req_tag   = tag;
    req_excl  = excl;
    while (!ready) @(negedge clk);
    exp_q.push_back(model_access(op, set_idx, tag, excl));
    n_sent++;
    @(negedge clk);
    req_valid = 1'b0;
    // the response belongs to the cycle right after acceptance
    check_value("resp_valid", resp_valid, 1);
  endtask

  always @(negedge clk) begin : compare_resp
    expect_t e;
    if (!rst) begin
      if (resp_valid) begin
        if (exp_q.size() == 0) begin
          fail_run("a response arrived with no request outstanding");
        end else begin
          e = exp_q.pop_front();
          n_resp++;
          check_value("resp_hit", resp_hit, e.hit);
          if (e.hit) begin
            check_value("resp_way", resp_way, e.way);
          end
          check_value("resp_excl", resp_excl, e.excl);
          check_value("resp_err", resp_err, 0);
          // ready drops only while an update is written
          check_value("ready", ready, !e.update);
          check_value("evict_valid", evict_valid, e.evict);
          if (e.evict) begin
            check_value("evict_tag", evict_tag, e.evict_tag);
          end
        end
      end else begin
        check_value("evict_valid", evict_valid, 0);
      end
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    fail_run($sformatf("run timed out after %0d cycles", watchdog_cycles));
  end

  initial begin
    int                  cycles;
    logic [31:0]         r;
    logic [SET_BITS-1:0] s;
    tag_op_t             op;
    seed      = 48559;
    rst       = 1'b1;
    req_valid = 1'b0;
    req_op    = op_lookup;
    req_set   = '0;
    req_tag   = '0;
    req_excl  = 1'b0;
    n_sent    = 0;
    n_resp    = 0;
    ref_ptr   = '0;
    for (int i = 0; i < num_sets; i++) begin
      for (int w = 0; w < num_ways; w++) begin
        ref_tag[i][w]   = '0;
        ref_valid[i][w] = 1'b0;
        ref_excl[i][w]  = 1'b0;
      end
    end
    repeat (4) @(negedge clk);
    rst = 1'b0;
    check_value("ready", ready, 0);

    // sweep writes one set per cycle before ready rises
    cycles = 0;
    while (!ready) begin
      @(negedge clk);
      cycles++;
    end
    check_value("ready_delay", cycles, num_sets);

    // the sweep cleared everything, so these all miss
    for (int i = 0; i < n_miss; i++) begin
      send(op_lookup, SET_BITS'($random(seed)), tag_bits'($random(seed)), 1'b0);
    end

    // fill, hit, refill of the same tag
    send(op_fill, SET_BITS'(5), 20'h12345, 1'b1);
    send(op_lookup, SET_BITS'(5), 20'h12345, 1'b0);
    send(op_fill, SET_BITS'(5), 20'h12345, 1'b0);
    send(op_lookup, SET_BITS'(5), 20'h12345, 1'b0);

    // eight tags into one set where the last four evict by the pointer
    for (int i = 0; i < 8; i++) begin
      send(op_fill, SET_BITS'(6'h2a), 20'hA0000 + tag_bits'(i), i[0]);
      send(op_lookup, SET_BITS'(6'h2a), 20'hA0000 + tag_bits'(i), 1'b0);
    end

    // snoop invalidate frees a way that the next fill takes
    for (int i = 0; i < 4; i++) begin
      send(op_fill, SET_BITS'(6'h11), 20'hB0000 + tag_bits'(i), 1'b1);
    end
    send(op_inval, SET_BITS'(6'h11), 20'hB0002, 1'b0);
    send(op_lookup, SET_BITS'(6'h11), 20'hB0002, 1'b0);
    send(op_fill, SET_BITS'(6'h11), 20'hB0010, 1'b0);
    send(op_lookup, SET_BITS'(6'h11), 20'hB0010, 1'b0);
    send(op_inval, SET_BITS'(6'h11), 20'hBFFFF, 1'b0);
    send(op_lookup, SET_BITS'(6'h11), 20'hB0000, 1'b0);
    send(op_lookup, SET_BITS'(6'h11), 20'hB0001, 1'b0);
    send(op_lookup, SET_BITS'(6'h11), 20'hB0003, 1'b0);
    send(op_lookup, SET_BITS'(6'h11), 20'hB0010, 1'b0);

    // random traffic over four sets and eight tags
    for (int i = 0; i < n_rand; i++) begin
      r  = $random(seed);
      s  = SET_BITS'(6'h30) | SET_BITS'(r[1:0]);
      op = (r[4:2] < 3'd4) ? op_lookup : ((r[4:2] < 3'd7) ? op_fill : op_inval);
      send(op, s, 20'hC0000 + tag_bits'(r[7:5]), r[8]);
      if (r[12:9] == 4'd0) begin
        @(negedge clk);
      end
    end

    // every response is due by the falling edge where the last send returns
    repeat (3) @(negedge clk);
    check_value("resp_count", n_resp, n_sent);
    $display("TEST PASS");
    $finish;
  end

endmodule

//--- verilog.f
source/dcache_geom_pkg.sv
source/dcache_ctrl_pkg.sv
source/dcache_tag_if.sv
source/dcache_tag_ram.sv
source/dcache_tag_way.sv
source/dcache_sweep_counter.sv
source/dcache_way_select.sv
source/dcache_tag_ctrl.sv
source/dcache_tag_top.sv
tests/tb_dcache_tag.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_dcache_tag \
  -o sim_dcache_tag

./obj_dir/sim_dcache_tag > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASS" sim.log; then
  exit 0
fi
exit 1
